/* mmio_bridge.f */
+incdir+src
src/mmio_bridge_pkg.sv
src/mmio_req_if.sv
src/mmio_addr_decode.sv
src/mmio_packet_encode.sv
src/mmio_slot_mem.sv
src/mmio_reorder_buf.sv
src/mmio_ctrl.sv
src/mmio_bridge.sv
sim/tb_mmio_bridge.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the MMIO bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f mmio_bridge.f \
  --top-module tb_mmio_bridge -o sim_mmio_bridge > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/sim_mmio_bridge > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "Simulation reported failure, see sim.log"
  exit 1
fi

echo "Simulation finished, see sim.log"
exit 0

/* sim/tb_mmio_bridge.sv */
`default_nettype none

`include "mmio_bridge_macros.svh"

module tb_mmio_bridge;
  import mmio_bridge_pkg::*;

  localparam int n_req_lp   = 400;
  localparam int limit_lp   = 50 * n_req_lp + 200;

  logic                     clk_i;
  logic                     rst_n_i;
  logic                     req_v_i;
  logic                     req_ready_o;
  mem_msg_e                 req_msg_i;
  amo_op_e                  req_amo_i;
  msg_size_e                req_size_i;
  logic [`MMIO_PADDR_W-1:0] req_addr_i;
  logic [`MMIO_WORD_W-1:0]  req_data_i;
  logic                     pkt_v_o;
  logic                     pkt_ready_i;
  net_op_e                  pkt_op_o;
  logic [`MMIO_EPA_W-1:0]   pkt_addr_o;
  logic [`MMIO_X_W-1:0]     pkt_x_o;
  logic [`MMIO_Y_W-1:0]     pkt_y_o;
  logic [`MMIO_X_W-1:0]     pkt_src_x_o;
  logic [`MMIO_Y_W-1:0]     pkt_src_y_o;
  logic [`MMIO_WORD_W-1:0]  pkt_data_o;
  logic [3:0]               pkt_mask_o;
  logic                     pkt_byte_o;
  logic                     pkt_hex_o;
  logic [1:0]               pkt_part_o;
  slot_id_t                 pkt_id_o;
  logic                     ret_v_i;
  slot_id_t                 ret_id_i;
  logic [`MMIO_WORD_W-1:0]  ret_data_i;
  logic                     rsp_v_o;
  logic                     rsp_ready_i;
  mem_msg_e                 rsp_msg_o;
  amo_op_e                  rsp_amo_o;
  msg_size_e                rsp_size_o;
  logic [`MMIO_PADDR_W-1:0] rsp_addr_o;
  logic [`MMIO_FILL_W-1:0]  rsp_data_o;
  logic [`MMIO_X_W-1:0]     host_x_i;
  logic [`MMIO_Y_W-1:0]     host_y_i;
  logic [`MMIO_X_W-1:0]     my_x_i;
  logic [`MMIO_Y_W-1:0]     my_y_i;

  // Model state
  int                       errors;
  int                       checks;
  int                       issued;
  int                       rsp_cnt;
  int                       cycles;
  logic                     running;
  logic                     fired;
  logic                     found;
  logic                     exp_ready;
  logic                     exp_rsp_v;
  logic                     hold_v;
  logic [`MMIO_FILL_W-1:0]  hold_data;
  logic [`MMIO_PADDR_W-1:0] hold_addr;
  slot_id_t                 start;
  slot_id_t                 sel;
  slot_id_t                 eid;
  mem_hdr_s                 eh;
  logic [`MMIO_WORD_W-1:0]  word;
  logic                     pend_v [`MMIO_SLOTS];
  int                       pend_dly [`MMIO_SLOTS];
  logic                     ret_seen [`MMIO_SLOTS];
  logic [`MMIO_WORD_W-1:0]  model_word [`MMIO_SLOTS];
  mem_hdr_s                 exp_hdr_q [$];
  slot_id_t                 exp_id_q [$];

  mmio_bridge dut0 (.*);

  always #4 clk_i = ~clk_i;

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Class 0 compute tile, 1 cache tile, 2 host
  function automatic logic [`MMIO_PADDR_W-1:0] random_addr(input int cls);
    logic [`MMIO_PADDR_W-1:0] a;
    a = {8'($urandom), $urandom};
    case (cls)
      0:       a[39:38] = 2'b11;
      1:       a[39:38] = 2'b10;
      default: a[39]    = 1'b0;
    endcase
    return a;
  endfunction

  function automatic logic [`MMIO_FILL_W-1:0] replicate(input msg_size_e size,
                                                       input logic [31:0] w);
    case (size)
      e_size_1: return {8{w[7:0]}};
      e_size_2: return {4{w[15:0]}};
      default:  return {2{w}};
    endcase
  endfunction

  task automatic expect_route(input logic [`MMIO_PADDR_W-1:0] a, output logic [26:0] epa,
                              output logic [6:0] x, output logic [6:0] y);
    logic [2:0] pod;
    pod = 3'b000;
    case (a[39:38])
      2'b11:
      begin
        epa = 27'(a[17:2]);
        x   = a[24:18];
        y   = a[31:25];
      end
      2'b10:
      begin
        epa = a[28:2];
        x   = a[35:29];
        pod = a[38:36] << 1;
        y   = {pod, pod[1] ? 4'h0 : 4'hf};
      end
      default:
      begin
        epa = a[28:2];
        x   = host_x_i;
        y   = host_y_i;
      end
    endcase
  endtask

  task automatic check_packet();
    logic [26:0] e_epa;
    logic [6:0]  e_x;
    logic [6:0]  e_y;
    logic [3:0]  e_mask;
    net_op_e     e_op;
    expect_route(req_addr_i, e_epa, e_x, e_y);
    check_value("pkt_addr_o", 64'(pkt_addr_o), 64'(e_epa));
    check_value("pkt_x_o", 64'(pkt_x_o), 64'(e_x));
    check_value("pkt_y_o", 64'(pkt_y_o), 64'(e_y));
    check_value("pkt_src_x_o", 64'(pkt_src_x_o), 64'(my_x_i));
    check_value("pkt_src_y_o", 64'(pkt_src_y_o), 64'(my_y_i));
    check_value("pkt_id_o", 64'(pkt_id_o), 64'(slot_id_t'(issued)));
    e_mask = 4'h0;
    case (req_msg_i)
      e_msg_uc_rd:
      begin
        e_op = e_net_load;
        check_value("pkt_byte_o", 64'(pkt_byte_o), 64'(req_size_i == e_size_1));
        check_value("pkt_hex_o", 64'(pkt_hex_o), 64'(req_size_i == e_size_2));
        check_value("pkt_part_o", 64'(pkt_part_o), 64'(req_addr_i[1:0]));
      end
      e_msg_uc_wr:
      begin
        e_op   = e_net_store;
        e_mask = (req_size_i == e_size_1) ? 4'h1 : (req_size_i == e_size_2) ? 4'h3 : 4'hf;
        e_mask = e_mask << req_addr_i[1:0];
        check_value("pkt_data_o", 64'(pkt_data_o), 64'(req_data_i));
      end
      default:
      begin
        e_op = (req_amo_i == e_amo_add) ? e_net_amoadd :
               (req_amo_i == e_amo_or) ? e_net_amoor : e_net_amoswap;
        check_value("pkt_data_o", 64'(pkt_data_o), 64'(req_data_i));
      end
    endcase
    check_value("pkt_op_o", 64'(pkt_op_o), 64'(e_op));
    check_value("pkt_mask_o", 64'(pkt_mask_o), 64'(e_mask));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Response checks, network responder and request driver
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i)
  begin
    if (running)
    begin
      // Head is valid once its reply reached the DUT on an earlier edge
      exp_rsp_v = 1'b0;
      if (exp_id_q.size() != 0)
        exp_rsp_v = ret_seen[exp_id_q[0]];
      check_value("rsp_v_o", 64'(rsp_v_o), 64'(exp_rsp_v));
      exp_ready = pkt_ready_i && (issued - rsp_cnt < `MMIO_SLOTS);

      if (hold_v)
      begin
        check_value("rsp_v_o held", 64'(rsp_v_o), 64'(1));
        check_value("rsp_data_o held", rsp_data_o, hold_data);
        check_value("rsp_addr_o held", 64'(rsp_addr_o), 64'(hold_addr));
      end
      hold_v    = rsp_v_o && !rsp_ready_i;
      hold_data = rsp_data_o;
      hold_addr = rsp_addr_o;
      if (rsp_v_o && rsp_ready_i)
      begin
        if (exp_hdr_q.size() == 0)
        begin
          errors++;
          $display("Response at %0t with no request outstanding", $time);
        end
        else
        begin
          eh  = exp_hdr_q.pop_front();
          eid = exp_id_q.pop_front();
          check_value("rsp_msg_o", 64'(rsp_msg_o), 64'(eh.msg));
          check_value("rsp_amo_o", 64'(rsp_amo_o), 64'(eh.amo));
          check_value("rsp_size_o", 64'(rsp_size_o), 64'(eh.size));
          check_value("rsp_addr_o", 64'(rsp_addr_o), 64'(eh.addr));
          check_value("rsp_data_o", rsp_data_o, replicate(eh.size, model_word[eid]));
          ret_seen[eid] = 1'b0;
          rsp_cnt++;
        end
      end

      // The reply driven last cycle is taken by the DUT at this edge
      if (ret_v_i)
        ret_seen[ret_id_i] = 1'b1;

      // Reply to one expired id, scanning from a random slot
      ret_v_i <= 1'b0;
      start = slot_id_t'($urandom);
      found = 1'b0;
      for (int i = 0; i < `MMIO_SLOTS; i++)
      begin
        sel = start + slot_id_t'(i);
        if (!found && pend_v[sel] && pend_dly[sel] == 0)
        begin
          found           = 1'b1;
          pend_v[sel]     = 1'b0;
          word            = $urandom;
          model_word[sel] = word;
          ret_v_i    <= 1'b1;
          ret_id_i   <= sel;
          ret_data_i <= word;
        end
      end
      for (int i = 0; i < `MMIO_SLOTS; i++)
      begin
        sel = slot_id_t'(i);
        if (pend_dly[sel] > 0)
          pend_dly[sel]--;
      end

      check_value("req_ready_o", 64'(req_ready_o), 64'(exp_ready));
      check_value("pkt_v_o", 64'(pkt_v_o), 64'(req_v_i && exp_ready));
      fired = req_v_i && req_ready_o;
      if (fired)
      begin
        check_packet();
        eh = '{msg: req_msg_i, amo: req_amo_i, size: req_size_i, addr: req_addr_i};
        exp_hdr_q.push_back(eh);
        exp_id_q.push_back(pkt_id_o);
        pend_v[pkt_id_o]   = 1'b1;
        pend_dly[pkt_id_o] = int'($urandom % 24);
        issued++;
      end
      if (issued - rsp_cnt > `MMIO_SLOTS)
      begin
        errors++;
        $display("More than %0d requests outstanding at %0t", `MMIO_SLOTS, $time);
      end

      // Hold a request until it is taken
      if (!req_v_i || fired)
      begin
        if (issued < n_req_lp && ($urandom % 4) != 0)
        begin
          req_v_i    <= 1'b1;
          req_msg_i  <= mem_msg_e'(2'($urandom % 3));
          req_amo_i  <= amo_op_e'(2'($urandom % 3));
          req_size_i <= msg_size_e'(2'($urandom % 3));
          req_addr_i <= random_addr(int'($urandom % 3));
          req_data_i <= $urandom;
        end
        else
          req_v_i <= 1'b0;
      end
      pkt_ready_i <= ($urandom % 4) != 0;
      rsp_ready_i <= ($urandom % 3) != 0;
    end
  end

  initial
  begin
    void'($urandom(32'h6c7));
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    req_v_i     = 1'b0;
    req_msg_i   = e_msg_uc_rd;
    req_amo_i   = e_amo_add;
    req_size_i  = e_size_1;
    req_addr_i  = '0;
    req_data_i  = '0;
    pkt_ready_i = 1'b0;
    ret_v_i     = 1'b0;
    ret_id_i    = '0;
    ret_data_i  = '0;
    rsp_ready_i = 1'b0;
    host_x_i    = 7'h05;
    host_y_i    = 7'h11;
    my_x_i      = 7'h2a;
    my_y_i      = 7'h13;
    errors      = 0;
    checks      = 0;
    issued      = 0;
    rsp_cnt     = 0;
    running     = 1'b0;
    hold_v      = 1'b0;
    for (int i = 0; i < `MMIO_SLOTS; i++)
    begin
      sel             = slot_id_t'(i);
      pend_v[sel]     = 1'b0;
      pend_dly[sel]   = 0;
      ret_seen[sel]   = 1'b0;
      model_word[sel] = '0;
    end
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    check_value("pkt_v_o after reset", 64'(pkt_v_o), 64'(0));
    check_value("rsp_v_o after reset", 64'(rsp_v_o), 64'(0));
    running <= 1'b1;
    cycles = 0;
    while (rsp_cnt < n_req_lp && cycles < limit_lp)
    begin
      @(negedge clk_i);
      cycles++;
    end
    if (rsp_cnt < n_req_lp)
    begin
      errors++;
      $display("Timeout after %0d cycles with %0d of %0d responses", cycles, rsp_cnt, n_req_lp);
    end
    $display("Requests %0d  responses %0d  checks %0d  errors %0d",
             issued, rsp_cnt, checks, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* src/mmio_addr_decode.sv */
`default_nettype none

`include "mmio_bridge_macros.svh"

module mmio_addr_decode (
  mmio_req_if.dp                 req_if,
  input  logic [`MMIO_X_W-1:0]   host_x_i,
  input  logic [`MMIO_Y_W-1:0]   host_y_i,
  output logic [`MMIO_EPA_W-1:0] epa_o,
  output logic [`MMIO_X_W-1:0]   dst_x_o,
  output logic [`MMIO_Y_W-1:0]   dst_y_o
);

  localparam int tile_epa_w_lp = `MMIO_TILE_AW - 2;
  localparam int vc_epa_w_lp   = `MMIO_VC_AW - 2;
  localparam int vc_pod_lsb_lp = `MMIO_VC_AW + `MMIO_X_W;

  logic [`MMIO_PADDR_W-1:0] addr;
  logic [1:0]               dst_sel;
  logic [tile_epa_w_lp-1:0] tile_epa;
  logic [`MMIO_X_W-1:0]     tile_x;
  logic [`MMIO_Y_W-1:0]     tile_y;
  logic [vc_epa_w_lp-1:0]   vc_epa;
  logic [`MMIO_X_W-1:0]     vc_x;
  logic [`MMIO_POD_Y_W-1:0] vc_pod;
  logic [`MMIO_SUBY_W-1:0]  vc_suby;

  assign addr    = req_if.hdr.addr;
  assign dst_sel = addr[`MMIO_PADDR_W-1 -: 2];

  // Compute tile, y sits right above the x field
  assign tile_epa = addr[2 +: tile_epa_w_lp];
  assign tile_x   = addr[`MMIO_TILE_AW +: `MMIO_X_W];
  assign tile_y   = addr[`MMIO_TILE_AW + `MMIO_X_W +: `MMIO_Y_W];

  // Cache tile. Pods are even, so the pod index is shifted up by one
  assign vc_epa  = addr[2 +: vc_epa_w_lp];
  assign vc_x    = addr[`MMIO_VC_AW +: `MMIO_X_W];
  assign vc_pod  = {addr[vc_pod_lsb_lp +: `MMIO_POD_Y_W-1], 1'b0};
  // North row of caches below the pod, south row above it
  assign vc_suby = vc_pod[1] ? '0 : '1;

  always_comb
  begin
    case (dst_sel)
      2'b11:
      begin
        epa_o   = `MMIO_EPA_W'(tile_epa);
        dst_x_o = tile_x;
        dst_y_o = tile_y;
      end
      2'b10:
      begin
        epa_o   = vc_epa;
        dst_x_o = vc_x;
        dst_y_o = {vc_pod, vc_suby};
      end
      default:
      begin
        epa_o   = addr[2 +: `MMIO_EPA_W];
        dst_x_o = host_x_i;
        dst_y_o = host_y_i;
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/mmio_bridge.sv */
`default_nettype none

`include "mmio_bridge_macros.svh"

module mmio_bridge (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // Request in
  input  logic                       req_v_i,
  output logic                       req_ready_o,
  input  mmio_bridge_pkg::mem_msg_e  req_msg_i,
  input  mmio_bridge_pkg::amo_op_e   req_amo_i,
  input  mmio_bridge_pkg::msg_size_e req_size_i,
  input  logic [`MMIO_PADDR_W-1:0]   req_addr_i,
  input  logic [`MMIO_WORD_W-1:0]    req_data_i,
  // Packet out, pkt_v_o depends combinationally on pkt_ready_i
  output logic                       pkt_v_o,
  input  logic                       pkt_ready_i,
  output mmio_bridge_pkg::net_op_e   pkt_op_o,
  output logic [`MMIO_EPA_W-1:0]     pkt_addr_o,
  output logic [`MMIO_X_W-1:0]       pkt_x_o,
  output logic [`MMIO_Y_W-1:0]       pkt_y_o,
  output logic [`MMIO_X_W-1:0]       pkt_src_x_o,
  output logic [`MMIO_Y_W-1:0]       pkt_src_y_o,
  output logic [`MMIO_WORD_W-1:0]    pkt_data_o,
  output logic [3:0]                 pkt_mask_o,
  output logic                       pkt_byte_o,
  output logic                       pkt_hex_o,
  output logic [1:0]                 pkt_part_o,
  output mmio_bridge_pkg::slot_id_t  pkt_id_o,
  // Reply in, always accepted
  input  logic                       ret_v_i,
  input  mmio_bridge_pkg::slot_id_t  ret_id_i,
  input  logic [`MMIO_WORD_W-1:0]    ret_data_i,
  // Response out
  output logic                       rsp_v_o,
  input  logic                       rsp_ready_i,
  output mmio_bridge_pkg::mem_msg_e  rsp_msg_o,
  output mmio_bridge_pkg::amo_op_e   rsp_amo_o,
  output mmio_bridge_pkg::msg_size_e rsp_size_o,
  output logic [`MMIO_PADDR_W-1:0]   rsp_addr_o,
  output logic [`MMIO_FILL_W-1:0]    rsp_data_o,
  // Straps
  input  logic [`MMIO_X_W-1:0]       host_x_i,
  input  logic [`MMIO_Y_W-1:0]       host_y_i,
  input  logic [`MMIO_X_W-1:0]       my_x_i,
  input  logic [`MMIO_Y_W-1:0]       my_y_i
);
  import mmio_bridge_pkg::*;

  logic     slot_free;
  logic     head_v;
  logic     deq;
  mem_hdr_s head_hdr;

  mmio_req_if req_if (.clk_i(clk_i));

  //////////////////////////////////////////////////////////////////////
  // Outgoing request path
  //////////////////////////////////////////////////////////////////////

  mmio_ctrl ctrl0 (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_v_i    (req_v_i),
    .req_ready_o(req_ready_o),
    .req_msg_i  (req_msg_i),
    .req_amo_i  (req_amo_i),
    .req_size_i (req_size_i),
    .req_addr_i (req_addr_i),
    .req_data_i (req_data_i),
    .pkt_ready_i(pkt_ready_i),
    .pkt_v_o    (pkt_v_o),
    .slot_free_i(slot_free),
    .rsp_ready_i(rsp_ready_i),
    .head_v_i   (head_v),
    .rsp_v_o    (rsp_v_o),
    .deq_o      (deq),
    .req_if     (req_if.ctrl)
  );

  mmio_addr_decode decode0 (
    .req_if  (req_if.dp),
    .host_x_i(host_x_i),
    .host_y_i(host_y_i),
    .epa_o   (pkt_addr_o),
    .dst_x_o (pkt_x_o),
    .dst_y_o (pkt_y_o)
  );

  mmio_packet_encode encode0 (
    .req_if(req_if.dp),
    .op_o  (pkt_op_o),
    .data_o(pkt_data_o),
    .mask_o(pkt_mask_o),
    .byte_o(pkt_byte_o),
    .hex_o (pkt_hex_o),
    .part_o(pkt_part_o)
  );

  assign pkt_id_o    = req_if.id;
  assign pkt_src_x_o = my_x_i;
  assign pkt_src_y_o = my_y_i;

  //////////////////////////////////////////////////////////////////////
  // Reply reordering
  //////////////////////////////////////////////////////////////////////

  mmio_reorder_buf rob0 (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_if     (req_if.alloc),
    .ret_v_i    (ret_v_i),
    .ret_id_i   (ret_id_i),
    .ret_data_i (ret_data_i),
    .deq_i      (deq),
    .slot_free_o(slot_free),
    .head_v_o   (head_v),
    .head_hdr_o (head_hdr),
    .rsp_data_o (rsp_data_o)
  );

  // Header of the oldest request, echoed back
  assign rsp_msg_o  = head_hdr.msg;
  assign rsp_amo_o  = head_hdr.amo;
  assign rsp_size_o = head_hdr.size;
  assign rsp_addr_o = head_hdr.addr;

endmodule

`default_nettype wire

/* src/mmio_bridge_macros.svh */
`ifndef MMIO_BRIDGE_MACROS_SVH
`define MMIO_BRIDGE_MACROS_SVH

// Processor side
`define MMIO_PADDR_W   40
`define MMIO_FILL_W    64

// Network word and coordinates
`define MMIO_WORD_W    32
`define MMIO_X_W       7
`define MMIO_Y_W       7
`define MMIO_POD_Y_W   3
`define MMIO_SUBY_W    4
`define MMIO_EPA_W     27

// Address spans behind one tile and one cache tile
`define MMIO_TILE_AW   18
`define MMIO_VC_AW     29

// Transactions in flight, a power of two
`define MMIO_SLOTS     8

`endif

/* src/mmio_bridge_pkg.sv */
`default_nettype none

`include "mmio_bridge_macros.svh"

package mmio_bridge_pkg;

  // Uncached message classes from the processor
  typedef enum logic [1:0] {
    e_msg_uc_rd = 2'b00,
    e_msg_uc_wr = 2'b01,
    e_msg_amo   = 2'b10
  } mem_msg_e;

  // Atomic sub-operations carried to the network
  typedef enum logic [1:0] {
    e_amo_add  = 2'b00,
    e_amo_or   = 2'b01,
    e_amo_swap = 2'b10
  } amo_op_e;

  // Access size, log2 of bytes
  typedef enum logic [1:0] {
    e_size_1 = 2'b00,
    e_size_2 = 2'b01,
    e_size_4 = 2'b10
  } msg_size_e;

  // Network packet opcodes
  typedef enum logic [2:0] {
    e_net_load    = 3'd0,
    e_net_store   = 3'd1,
    e_net_amoadd  = 3'd2,
    e_net_amoor   = 3'd3,
    e_net_amoswap = 3'd4
  } net_op_e;

  typedef logic [$clog2(`MMIO_SLOTS)-1:0] slot_id_t;

  // Request header, also echoed on the response
  typedef struct packed {
    mem_msg_e                 msg;
    amo_op_e                  amo;
    msg_size_e                size;
    logic [`MMIO_PADDR_W-1:0] addr;
  } mem_hdr_s;

endpackage

`default_nettype wire

/* src/mmio_ctrl.sv */
`default_nettype none

`include "mmio_bridge_macros.svh"

module mmio_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       req_v_i,
  output logic                       req_ready_o,
  input  mmio_bridge_pkg::mem_msg_e  req_msg_i,
  input  mmio_bridge_pkg::amo_op_e   req_amo_i,
  input  mmio_bridge_pkg::msg_size_e req_size_i,
  input  logic [`MMIO_PADDR_W-1:0]   req_addr_i,
  input  logic [`MMIO_WORD_W-1:0]    req_data_i,
  input  logic                       pkt_ready_i,
  output logic                       pkt_v_o,
  input  logic                       slot_free_i,
  input  logic                       rsp_ready_i,
  input  logic                       head_v_i,
  output logic                       rsp_v_o,
  output logic                       deq_o,
  mmio_req_if.ctrl                   req_if
);

  localparam int cnt_w_lp = $clog2(`MMIO_SLOTS) + 1;

  logic [cnt_w_lp-1:0] inflight_q;

  // Request and packet leave together, hence pkt_v_o follows pkt_ready_i
  assign req_ready_o = slot_free_i & pkt_ready_i;
  assign req_if.fire = req_v_i & req_ready_o;
  assign pkt_v_o     = req_if.fire;

  assign req_if.hdr  = '{msg: req_msg_i, amo: req_amo_i, size: req_size_i, addr: req_addr_i};
  assign req_if.data = req_data_i;

  // Head leaves once its reply is back
  assign rsp_v_o = head_v_i;
  assign deq_o   = rsp_v_o & rsp_ready_i;

  // Outstanding count as seen by the handshakes
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      inflight_q <= '0;
    end
    else
    begin
      case ({req_if.fire, deq_o})
        2'b10:   inflight_q <= inflight_q + cnt_w_lp'(1);
        2'b01:   inflight_q <= inflight_q - cnt_w_lp'(1);
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  // The reorder buffer must refuse a ninth request
  no_fire_when_full_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_if.fire |-> inflight_q < `MMIO_SLOTS)
    else $error("request fired with %0d slots in use", inflight_q);

endmodule

`default_nettype wire

/* src/mmio_packet_encode.sv */
`default_nettype none

`include "mmio_bridge_macros.svh"

module mmio_packet_encode (
  mmio_req_if.dp                   req_if,
  output mmio_bridge_pkg::net_op_e op_o,
  output logic [`MMIO_WORD_W-1:0]  data_o,
  output logic [3:0]               mask_o,
  output logic                     byte_o,
  output logic                     hex_o,
  output logic [1:0]               part_o
);
  import mmio_bridge_pkg::*;

  mem_hdr_s   hdr;
  logic [3:0] store_mask;

  assign hdr = req_if.hdr;

  // Byte lanes touched by a store
  always_comb
  begin
    case (hdr.size)
      e_size_1: store_mask = 4'h1 << hdr.addr[1:0];
      e_size_2: store_mask = 4'h3 << hdr.addr[1:0];
      default:  store_mask = 4'hf << hdr.addr[1:0];
    endcase
  end

  always_comb
  begin
    op_o   = e_net_store;
    data_o = req_if.data;
    mask_o = '0;
    byte_o = 1'b0;
    hex_o  = 1'b0;
    part_o = 2'b00;
    case (hdr.msg)
      e_msg_uc_rd:
      begin
        op_o   = e_net_load;
        data_o = '0;
        byte_o = (hdr.size == e_size_1);
        hex_o  = (hdr.size == e_size_2);
        part_o = hdr.addr[1:0];
      end
      e_msg_amo:
      begin
        case (hdr.amo)
          e_amo_add: op_o = e_net_amoadd;
          e_amo_or:  op_o = e_net_amoor;
          default:   op_o = e_net_amoswap;
        endcase
      end
      default:
        mask_o = store_mask;
    endcase
  end

  // Only three atomics exist on the network side
  amo_op_legal_a: assert property (@(posedge req_if.clk_i)
    req_if.fire && (hdr.msg == e_msg_amo) |-> hdr.amo inside {e_amo_add, e_amo_or, e_amo_swap})
    else $error("illegal atomic op %0d accepted", hdr.amo);

endmodule

`default_nettype wire

/* src/mmio_reorder_buf.sv */
`default_nettype none

`include "mmio_bridge_macros.svh"

module mmio_reorder_buf (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  mmio_req_if.alloc                 req_if,
  input  logic                      ret_v_i,
  input  mmio_bridge_pkg::slot_id_t ret_id_i,
  input  logic [`MMIO_WORD_W-1:0]   ret_data_i,
  input  logic                      deq_i,
  output logic                      slot_free_o,
  output logic                      head_v_o,
  output mmio_bridge_pkg::mem_hdr_s head_hdr_o,
  output logic [`MMIO_FILL_W-1:0]   rsp_data_o
);
  import mmio_bridge_pkg::*;

  slot_id_t                alloc_ptr_q;
  slot_id_t                deq_ptr_q;
  logic [`MMIO_SLOTS-1:0]  alloc_q;
  logic [`MMIO_SLOTS-1:0]  ret_q;
  logic [`MMIO_WORD_W-1:0] head_word;

  //////////////////////////////////////////////////////////////////////
  // Slot state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      alloc_ptr_q <= '0;
      deq_ptr_q   <= '0;
      alloc_q     <= '0;
      ret_q       <= '0;
    end
    else
    begin
      if (req_if.fire)
      begin
        alloc_q[alloc_ptr_q] <= 1'b1;
        alloc_ptr_q          <= alloc_ptr_q + slot_id_t'(1);
      end
      if (ret_v_i)
      begin
        ret_q[ret_id_i] <= 1'b1;
      end
      // Head slot has returned, so no reply can hit it this cycle
      if (deq_i)
      begin
        alloc_q[deq_ptr_q] <= 1'b0;
        ret_q[deq_ptr_q]   <= 1'b0;
        deq_ptr_q          <= deq_ptr_q + slot_id_t'(1);
      end
    end
  end

  // Ids go out in order, so the next one is free only once it drained
  assign slot_free_o = ~alloc_q[alloc_ptr_q];
  assign req_if.id   = alloc_ptr_q;
  assign head_v_o    = ret_q[deq_ptr_q];

  //////////////////////////////////////////////////////////////////////
  // Header and reply storage
  //////////////////////////////////////////////////////////////////////

  mmio_slot_mem #(
    .entry_t(mem_hdr_s)
  ) hdr_mem (
    .clk_i    (clk_i),
    .wr_i     (req_if.fire),
    .wr_id_i  (alloc_ptr_q),
    .wr_data_i(req_if.hdr),
    .rd_id_i  (deq_ptr_q),
    .rd_data_o(head_hdr_o)
  );

  // Reply word of every returned slot
  mmio_slot_mem #(
    .entry_t(logic [`MMIO_WORD_W-1:0])
  ) word_mem (
    .clk_i    (clk_i),
    .wr_i     (ret_v_i),
    .wr_id_i  (ret_id_i),
    .wr_data_i(ret_data_i),
    .rd_id_i  (deq_ptr_q),
    .rd_data_o(head_word)
  );

  // Fill the response bus with copies of the accessed bytes
  always_comb
  begin
    case (head_hdr_o.size)
      e_size_1: rsp_data_o = {(`MMIO_FILL_W/8){head_word[7:0]}};
      e_size_2: rsp_data_o = {(`MMIO_FILL_W/16){head_word[15:0]}};
      default:  rsp_data_o = {(`MMIO_FILL_W/`MMIO_WORD_W){head_word}};
    endcase
  end

  ret_id_live_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ret_v_i |-> alloc_q[ret_id_i] && !ret_q[ret_id_i])
    else $error("reply for slot %0d that is not outstanding", ret_id_i);

endmodule

`default_nettype wire

/* src/mmio_req_if.sv */
`default_nettype none

`include "mmio_bridge_macros.svh"

interface mmio_req_if (
  input logic clk_i
);
  import mmio_bridge_pkg::*;

  mem_hdr_s                hdr;
  logic [`MMIO_WORD_W-1:0] data;
  logic                    fire;
  slot_id_t                id;

  // Handshake side, owns the request fields
  modport ctrl (
    output hdr,
    output data,
    output fire
  );

  // Id allocation and header capture
  modport alloc (
    input  hdr,
    input  fire,
    output id
  );

  // Combinational datapath
  modport dp (
    input clk_i,
    input hdr,
    input data,
    input fire
  );

endinterface

`default_nettype wire

/* src/mmio_slot_mem.sv */
`default_nettype none

`include "mmio_bridge_macros.svh"

module mmio_slot_mem #(
  parameter type entry_t = logic [`MMIO_WORD_W-1:0]
) (
  input  logic                      clk_i,
  input  logic                      wr_i,
  input  mmio_bridge_pkg::slot_id_t wr_id_i,
  input  entry_t                    wr_data_i,
  input  mmio_bridge_pkg::slot_id_t rd_id_i,
  output entry_t                    rd_data_o
);

  entry_t mem_q [`MMIO_SLOTS];

  always_ff @(posedge clk_i)
  begin
    if (wr_i)
    begin
      mem_q[wr_id_i] <= wr_data_i;
    end
  end

  // Read is asynchronous
  assign rd_data_o = mem_q[rd_id_i];

endmodule

`default_nettype wire
